/* Makefile */
TOP := pwm_generator_tb

sim:
	verilator --binary --assert --top-module $(TOP) -f pwm_generator.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -F -x '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* hdl/pwm_carrier_counter.sv */
`default_nettype none

module pwm_carrier_counter (
    input  wire logic                               clock,
    input  wire logic                               rst_n,
    input  wire logic                               run,
    input  wire logic                               ext_sel,
    input  wire logic                               ext_timebase,
    input  wire pwm_pkg::pwm_timing_t               timing,
    output logic [pwm_pkg::counter_width-1:0]       count,
    output logic                                    period_end
);

    import pwm_pkg::*;

    logic [counter_width-1:0] prescale_count;
    logic                     internal_tick;
    logic [1:0]               ext_sync;
    logic                     ext_prev;
    logic                     ext_rise;
    logic                     tick;

    // Two flop synchronizer for the asynchronous external timebase
    // followed by a delayed copy for rising edge detection
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ext_sync <= '0;
            ext_prev <= 1'b0;
        end else begin
            ext_sync <= {ext_sync[0], ext_timebase};
            ext_prev <= ext_sync[1];
        end
    end

    assign ext_rise = ext_sync[1] && !ext_prev;

    // The divider wraps after prescale+1 clocks and produces one internal tick
    assign internal_tick = (prescale_count == timing.prescale);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            prescale_count <= '0;
        end else if (!run || internal_tick) begin
            prescale_count <= '0;
        end else begin
            prescale_count <= prescale_count + 1'b1;
        end
    end

    // Select the tick source, nothing advances while stopped
    assign tick = run && (ext_sel ? ext_rise : internal_tick);

    // The last tick of a carrier period
    assign period_end = tick && (count == timing.period);

    // Sawtooth carrier counting from 0 up to period inclusive
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!run || period_end) begin
            count <= '0;
        end else if (tick) begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/pwm_comparator_bank.sv */
`default_nettype none

module pwm_comparator_bank (
    input  wire logic                                  clock,
    input  wire logic                                  rst_n,
    input  wire logic                                  run,
    input  wire logic [pwm_pkg::counter_width-1:0]     count,
    input  wire pwm_pkg::pwm_compare_t                 compare,
    output logic [2*pwm_pkg::n_channels-1:0]           pwm_out
);

    import pwm_pkg::*;

    // Unregistered high side of every channel
    logic [n_channels-1:0] high_side;

    // High while the carrier is below the compare value
    // A compare above the period keeps the output high for the whole period
    always_comb begin
        for (int i = 0; i < n_channels; i++) begin
            high_side[i] = count < compare.value[i];
        end
    end

    // Register the pairs, both sides go low when the carrier is halted
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pwm_out <= '0;
        end else begin
            for (int i = 0; i < n_channels; i++) begin
                pwm_out[2*i]   <= run && high_side[i];
                pwm_out[2*i+1] <= run && !high_side[i];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/pwm_control_fsm.sv */
`default_nettype none

module pwm_control_fsm (
    input  wire logic             clock,
    input  wire logic             rst_n,
    input  wire logic             enable,
    input  wire logic             fault,
    input  wire logic             fault_clear,
    input  wire logic             period_end,
    output logic                  run,
    output logic                  shadow_load,
    output pwm_pkg::pwm_status_t  status
);

    import pwm_pkg::*;

    pwm_state_t state;
    pwm_state_t next_state;

    always_comb begin
        next_state = state;
        // A fault takes priority over every other transition
        if (fault) begin
            next_state = st_faulted;
        end else begin
            case (state)
                st_stopped:  if (enable) next_state = st_running;
                st_running:  if (!enable) next_state = st_stopping;
                // Let the current carrier period finish before stopping
                st_stopping: if (period_end) next_state = st_stopped;
                // The fault input is already known to be low here
                st_faulted:  if (fault_clear) next_state = st_stopped;
                default:     next_state = st_stopped;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= st_stopped;
        end else begin
            state <= next_state;
        end
    end

    // The carrier runs until the stop completes or a fault hits
    assign run = (state == st_running) || (state == st_stopping);

    // Shadows follow the staged values while idle, and only at period end while running
    assign shadow_load = !run || period_end;

    assign status.state         = state;
    assign status.fault_latched = (state == st_faulted);

endmodule

`default_nettype wire

/* hdl/pwm_generator.sv */
`default_nettype none

module pwm_generator (
    input  wire logic                          clock,
    input  wire logic                          rst_n,
    input  wire logic                          ext_timebase,
    input  wire logic                          fault,
    input  wire sb_pkg::sb_req_t               sb_req,
    output sb_pkg::sb_resp_t                   sb_resp,
    output logic [2*pwm_pkg::n_channels-1:0]   pwm_out
);

    import pwm_pkg::*;

    // Configuration as written by the bus master
    pwm_control_t             control;
    pwm_timing_t              staged_timing;
    pwm_compare_t             staged_compare;
    logic                     fault_clear;

    // Configuration in use by the carrier and the comparators
    pwm_timing_t              active_timing;
    pwm_compare_t             active_compare;

    pwm_status_t              status;
    logic                     run;
    logic                     shadow_load;
    logic [counter_width-1:0] count;
    logic                     period_end;

    pwm_register_file registers (
        .clock          (clock),
        .rst_n          (rst_n),
        .sb_req         (sb_req),
        .status         (status),
        .sb_resp        (sb_resp),
        .control        (control),
        .staged_timing  (staged_timing),
        .staged_compare (staged_compare),
        .fault_clear    (fault_clear)
    );

    pwm_control_fsm control_fsm (
        .clock       (clock),
        .rst_n       (rst_n),
        .enable      (control.enable),
        .fault       (fault),
        .fault_clear (fault_clear),
        .period_end  (period_end),
        .run         (run),
        .shadow_load (shadow_load),
        .status      (status)
    );

    pwm_carrier_counter carrier (
        .clock        (clock),
        .rst_n        (rst_n),
        .run          (run),
        .ext_sel      (control.ext_sel),
        .ext_timebase (ext_timebase),
        .timing       (active_timing),
        .count        (count),
        .period_end   (period_end)
    );

    // Timing and compare share one shadow design with different payloads
    pwm_shadow_reg #(.payload_t(pwm_timing_t)) timing_shadow (
        .clock  (clock),
        .rst_n  (rst_n),
        .load   (shadow_load),
        .staged (staged_timing),
        .active (active_timing)
    );

    pwm_shadow_reg #(.payload_t(pwm_compare_t)) compare_shadow (
        .clock  (clock),
        .rst_n  (rst_n),
        .load   (shadow_load),
        .staged (staged_compare),
        .active (active_compare)
    );

    pwm_comparator_bank comparators (
        .clock   (clock),
        .rst_n   (rst_n),
        .run     (run),
        .count   (count),
        .compare (active_compare),
        .pwm_out (pwm_out)
    );

endmodule

`default_nettype wire

/* hdl/pwm_pkg.sv */
`default_nettype none

// Widths and data types of the PWM datapath and its control
package pwm_pkg;

    // Width of the carrier, prescaler, period and compare values
    localparam int counter_width = 16;

    // Number of complementary output pairs
    localparam int n_channels = 4;

    // Control word as stored by the register file
    // The fault clear bit of the control register is a pulse and is not kept here
    typedef struct packed {
        logic enable;
        logic ext_sel;
    } pwm_control_t;

    // Timebase settings, shadowed as one unit
    typedef struct packed {
        logic [counter_width-1:0] prescale;
        logic [counter_width-1:0] period;
    } pwm_timing_t;

    // One compare value per channel, shadowed as one unit
    typedef struct packed {
        logic [n_channels-1:0][counter_width-1:0] value;
    } pwm_compare_t;

    // States of the control FSM
    typedef enum logic [1:0] {
        st_stopped  = 2'd0,
        st_running  = 2'd1,
        st_stopping = 2'd2,
        st_faulted  = 2'd3
    } pwm_state_t;

    // Status word returned to the bus
    typedef struct packed {
        pwm_state_t state;
        logic       fault_latched;
    } pwm_status_t;

endpackage

`default_nettype wire

/* hdl/pwm_register_file.sv */
`default_nettype none

module pwm_register_file (
    input  wire logic                  clock,
    input  wire logic                  rst_n,
    input  wire sb_pkg::sb_req_t       sb_req,
    input  wire pwm_pkg::pwm_status_t  status,
    output sb_pkg::sb_resp_t           sb_resp,
    output pwm_pkg::pwm_control_t      control,
    output pwm_pkg::pwm_timing_t       staged_timing,
    output pwm_pkg::pwm_compare_t      staged_compare,
    output logic                       fault_clear
);

    import sb_pkg::*;
    import pwm_pkg::*;

    // Byte offset of the access relative to the block base
    // Addresses below the base wrap to large values and miss every register
    logic [31:0] offset;
    logic [31:0] read_value;

    assign offset = sb_req.address - sb_base_addr;

    // Read multiplexer, unmapped or unaligned offsets return zero
    always_comb begin
        read_value = '0;
        case (offset)
            reg_control: begin
                read_value[0] = control.enable;
                read_value[1] = control.ext_sel;
            end
            reg_prescale:  read_value[counter_width-1:0] = staged_timing.prescale;
            reg_period:    read_value[counter_width-1:0] = staged_timing.period;
            reg_compare_0: read_value[counter_width-1:0] = staged_compare.value[0];
            reg_compare_1: read_value[counter_width-1:0] = staged_compare.value[1];
            reg_compare_2: read_value[counter_width-1:0] = staged_compare.value[2];
            reg_compare_3: read_value[counter_width-1:0] = staged_compare.value[3];
            reg_status: begin
                read_value[1:0] = status.state;
                read_value[2]   = status.fault_latched;
            end
            default: read_value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sb_resp        <= '0;
            control        <= '0;
            staged_timing  <= '0;
            staged_compare <= '0;
            fault_clear    <= 1'b0;
        end else begin
            // Every strobe gets exactly one ready in the following cycle
            sb_resp.ready     <= sb_req.read_strobe | sb_req.write_strobe;
            sb_resp.read_data <= sb_req.read_strobe ? read_value : '0;

            // The clear request only lives for one cycle
            fault_clear <= 1'b0;

            if (sb_req.write_strobe) begin
                case (offset)
                    reg_control: begin
                        control.enable  <= sb_req.write_data[0];
                        control.ext_sel <= sb_req.write_data[1];
                        fault_clear     <= sb_req.write_data[2];
                    end
                    reg_prescale: begin
                        staged_timing.prescale <= sb_req.write_data[counter_width-1:0];
                    end
                    reg_period: begin
                        staged_timing.period <= sb_req.write_data[counter_width-1:0];
                    end
                    reg_compare_0: begin
                        staged_compare.value[0] <= sb_req.write_data[counter_width-1:0];
                    end
                    reg_compare_1: begin
                        staged_compare.value[1] <= sb_req.write_data[counter_width-1:0];
                    end
                    reg_compare_2: begin
                        staged_compare.value[2] <= sb_req.write_data[counter_width-1:0];
                    end
                    reg_compare_3: begin
                        staged_compare.value[3] <= sb_req.write_data[counter_width-1:0];
                    end
                    // Status is read only and other offsets are not mapped
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/pwm_shadow_reg.sv */
`default_nettype none

module pwm_shadow_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire logic      clock,
    input  wire logic      rst_n,
    input  wire logic      load,
    input  wire payload_t  staged,
    output payload_t       active
);

    // Active copy used by the datapath
    // It only changes on a load so a period in progress keeps its settings
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            active <= '0;
        end else if (load) begin
            active <= staged;
        end
    end

endmodule

`default_nettype wire

/* hdl/sb_pkg.sv */
`default_nettype none

// Definitions for the plain strobe configuration bus
package sb_pkg;

    // Request from the bus master, held stable during the strobe cycle
    typedef struct packed {
        logic [31:0] address;
        logic        read_strobe;
        logic        write_strobe;
        logic [31:0] write_data;
    } sb_req_t;

    // Response from the slave, with ready high for one cycle after a strobe
    typedef struct packed {
        logic        ready;
        logic [31:0] read_data;
    } sb_resp_t;

    // Base address of the PWM block on the bus
    localparam logic [31:0] sb_base_addr = 32'h43C0_0000;

    // Byte offsets of the registers from the base address
    localparam logic [31:0] reg_control   = 32'h00;
    localparam logic [31:0] reg_prescale  = 32'h04;
    localparam logic [31:0] reg_period    = 32'h08;
    localparam logic [31:0] reg_compare_0 = 32'h0C;
    localparam logic [31:0] reg_compare_1 = 32'h10;
    localparam logic [31:0] reg_compare_2 = 32'h14;
    localparam logic [31:0] reg_compare_3 = 32'h18;
    // Read only view of the state machine
    localparam logic [31:0] reg_status    = 32'h1C;

endpackage

`default_nettype wire

/* pwm_generator.f */
hdl/sb_pkg.sv
hdl/pwm_pkg.sv
hdl/pwm_shadow_reg.sv
hdl/pwm_register_file.sv
hdl/pwm_control_fsm.sv
hdl/pwm_carrier_counter.sv
hdl/pwm_comparator_bank.sv
hdl/pwm_generator.sv
sim/pwm_generator_assertions.sv
sim/pwm_generator_tb.sv

/* sim/pwm_generator_assertions.sv */
`default_nettype none

module pwm_generator_assertions (
    input wire logic                                clock,
    input wire logic                                rst_n,
    input wire logic                                fault,
    input wire sb_pkg::sb_req_t                     sb_req,
    input wire sb_pkg::sb_resp_t                    sb_resp,
    input wire logic [2*pwm_pkg::n_channels-1:0]    pwm_out
);

    import pwm_pkg::*;

    // Every ready answers a strobe of the previous cycle
    ready_after_strobe: assert property (@(posedge clock) disable iff (!rst_n)
        sb_resp.ready |-> $past(sb_req.read_strobe || sb_req.write_strobe))
        else $error("ready without a strobe in the previous cycle");

    ready_one_cycle: assert property (@(posedge clock) disable iff (!rst_n)
        sb_resp.ready |=> !sb_resp.ready)
        else $error("ready stayed high for more than one cycle");

    // High side and complement of a channel never overlap
    for (genvar i = 0; i < n_channels; i++) begin : pair
        sides_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
            !(pwm_out[2*i] && pwm_out[2*i+1]))
            else $error("both sides of channel %0d are high", i);
    end

    // The FSM registers the fault, then the comparators clear the outputs
    fault_blanks_outputs: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(fault) |-> ##2 (pwm_out == '0))
        else $error("outputs still active two cycles after fault");

endmodule

bind pwm_generator pwm_generator_assertions checks (
    .clock   (clock),
    .rst_n   (rst_n),
    .fault   (fault),
    .sb_req  (sb_req),
    .sb_resp (sb_resp),
    .pwm_out (pwm_out)
);

`default_nettype wire

/* sim/pwm_generator_tb.sv */
`default_nettype none

module pwm_generator_tb;

    import sb_pkg::*;
    import pwm_pkg::*;

    localparam int clock_period = 100;
    // The external timebase toggles every ext_half clocks
    localparam int ext_half = 3;

    logic                    clock;
    logic                    rst_n;
    logic                    ext_timebase = 1'b0;
    logic                    fault;
    sb_req_t                 sb_req;
    sb_resp_t                sb_resp;
    logic [2*n_channels-1:0] pwm_out;

    int    seed = 32'h2bd8_6798;
    int    errors = 0;
    int    checks = 0;
    int    tests = 0;
    int    errors_at_start;
    string test_name;
    int    watchdog_clocks = 0;
    int    ext_phase = 0;

    // Configuration the stimulus has programmed into the DUT
    int cfg_prescale;
    int cfg_period;
    int cfg_compare [n_channels];

    // Request and result of one duty measurement by the comparing process
    logic measure_req;
    logic measure_done;
    logic window_open;
    int   window_clocks;
    int   exp_high [n_channels];

    pwm_generator uut (
        .clock        (clock),
        .rst_n        (rst_n),
        .ext_timebase (ext_timebase),
        .fault        (fault),
        .sb_req       (sb_req),
        .sb_resp      (sb_resp),
        .pwm_out      (pwm_out)
    );

    always #(clock_period / 2) clock = !clock;

    // Free running external timebase with a period of 2*ext_half clocks
    always @(negedge clock) begin
        ext_phase    <= (ext_phase + 1) % (2 * ext_half);
        ext_timebase <= (ext_phase < ext_half);
    end

    // High clocks per carrier period are min(compare, period+1) ticks of prescale+1 clocks
    function automatic int expected_high_clocks(int compare, int period, int prescale);
        int ticks;
        ticks = (compare < period + 1) ? compare : period + 1;
        return ticks * (prescale + 1);
    endfunction

    task automatic check_value(string what, int expected, int actual);
        checks++;
        assert (expected == actual) else begin
            $display("FAIL %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
            errors++;
        end
    endtask

    // Ready is due in the cycle after the strobe
    task automatic bus_finish(output logic [31:0] data);
        int waited;
        waited = 0;
        while (!sb_resp.ready && waited < 4) begin
            @(negedge clock);
            waited++;
        end
        checks++;
        assert (sb_resp.ready) else begin
            $display("ERROR %s: the DUT gave no ready after a bus strobe", test_name);
            errors++;
        end
        data = sb_resp.read_data;
    endtask

    task automatic bus_write(logic [31:0] offset, logic [31:0] data);
        logic [31:0] unused;
        @(negedge clock);
        sb_req.address      = sb_base_addr + offset;
        sb_req.write_data   = data;
        sb_req.write_strobe = 1'b1;
        @(negedge clock);
        sb_req.write_strobe = 1'b0;
        bus_finish(unused);
    endtask

    task automatic bus_read(input logic [31:0] offset, output logic [31:0] data);
        @(negedge clock);
        sb_req.address     = sb_base_addr + offset;
        sb_req.read_strobe = 1'b1;
        @(negedge clock);
        sb_req.read_strobe = 1'b0;
        bus_finish(data);
    endtask

    task automatic begin_test(string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    // Channel 0 always rises at count 0, so its rising edge marks a period start
    task automatic sync_to_period();
        logic prev;
        prev = 1'b1;
        @(negedge clock);
        while (!(pwm_out[0] && !prev)) begin
            prev = pwm_out[0];
            @(negedge clock);
        end
    endtask

    task automatic set_expected(int prescale);
        window_clocks = (cfg_period + 1) * (prescale + 1);
        for (int i = 0; i < n_channels; i++) begin
            exp_high[i] = expected_high_clocks(cfg_compare[i], cfg_period, prescale);
        end
    endtask

    task automatic measure_period();
        measure_req = 1'b1;
        wait (measure_done);
        measure_req = 1'b0;
        wait (!measure_done);
    endtask

    // Counts the high clocks of every output bit over one whole carrier period
    initial begin : compare_duty
        int high_clocks [2*n_channels];
        measure_done = 1'b0;
        window_open  = 1'b0;
        forever begin
            wait (measure_req);
            sync_to_period();
            window_open = 1'b1;
            for (int b = 0; b < 2 * n_channels; b++) begin
                high_clocks[b] = 0;
            end
            for (int n = 0; n < window_clocks; n++) begin
                for (int b = 0; b < 2 * n_channels; b++) begin
                    if (pwm_out[b]) high_clocks[b]++;
                end
                @(negedge clock);
            end
            window_open = 1'b0;
            // The low side owns whatever the high side leaves of the period
            for (int i = 0; i < n_channels; i++) begin
                check_value($sformatf("ch%0d high", i), exp_high[i], high_clocks[2*i]);
                check_value($sformatf("ch%0d low", i), window_clocks - exp_high[i],
                            high_clocks[2*i+1]);
            end
            measure_done = 1'b1;
            wait (!measure_req);
            measure_done = 1'b0;
        end
    end

    initial begin : watchdog
        wait (watchdog_clocks > 0);
        #(2 * watchdog_clocks * clock_period);
        $display("ERROR: the run did not finish within %0d clocks", 2 * watchdog_clocks);
        $display("** FAIL **");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] data;
        int          ref_value;
        int          nonzero_clocks;
        longint      t_start;
        clock        = 1'b0;
        rst_n        = 1'b0;
        fault        = 1'b0;
        sb_req       = '0;
        measure_req  = 1'b0;

        // Short periods keep the run brief
        // Compares may exceed the period and then saturate the output
        cfg_prescale   = $unsigned($random(seed)) % 4;
        cfg_period     = 8 + $unsigned($random(seed)) % 16;
        cfg_compare[0] = 1 + $unsigned($random(seed)) % cfg_period;
        for (int i = 1; i < n_channels; i++) begin
            cfg_compare[i] = $unsigned($random(seed)) % (cfg_period + 3);
        end
        // About twenty internal and six external carrier periods plus bus traffic
        watchdog_clocks = 316 + 20 * (cfg_period + 1) * (cfg_prescale + 1)
                        + 6 * (cfg_period + 1) * 2 * ext_half;

        repeat (16) @(negedge clock);
        rst_n = 1'b1;

        begin_test("readback");
        for (int r = 1; r < 7; r++) begin
            ref_value = $unsigned($random(seed)) % 65536;
            bus_write(32'(4 * r), ref_value);
            bus_read(32'(4 * r), data);
            check_value($sformatf("offset %0d", 4 * r), ref_value, data);
        end
        bus_write(reg_control, 32'h2);
        bus_read(reg_control, data);
        check_value("control", 2, data);
        bus_write(reg_control, 32'h0);
        bus_write(32'h20, 32'hffff);
        bus_read(32'h20, data);
        check_value("unmapped", 0, data);
        bus_read(32'h0010_0000, data);
        check_value("outside block", 0, data);
        end_test();

        begin_test("duty");
        bus_write(reg_prescale, cfg_prescale);
        bus_write(reg_period, cfg_period);
        for (int i = 0; i < n_channels; i++) begin
            bus_write(reg_compare_0 + 32'(4 * i), cfg_compare[i]);
        end
        bus_write(reg_control, 32'h1);
        set_expected(cfg_prescale);
        measure_period();
        end_test();

        // The old compare holds for the period in which the write lands
        begin_test("shadow");
        measure_req = 1'b1;
        wait (window_open);
        repeat (2) @(negedge clock);
        cfg_compare[1] = (cfg_compare[1] + 3) % (cfg_period + 2);
        bus_write(reg_compare_1, cfg_compare[1]);
        wait (measure_done);
        measure_req = 1'b0;
        wait (!measure_done);
        set_expected(cfg_prescale);
        measure_period();
        end_test();

        // Outputs go to zero exactly one period after the period start
        begin_test("stop");
        sync_to_period();
        t_start = $time;
        bus_write(reg_control, 32'h0);
        while (pwm_out != '0) @(negedge clock);
        check_value("active clocks", window_clocks, int'(($time - t_start) / clock_period));
        nonzero_clocks = 0;
        repeat (window_clocks) begin
            @(negedge clock);
            if (pwm_out != '0) nonzero_clocks++;
        end
        check_value("clocks active after stop", 0, nonzero_clocks);
        bus_read(reg_status, data);
        check_value("status", int'(st_stopped), data);
        end_test();

        // Each external rising edge is one tick and the edges come 2*ext_half clocks apart
        begin_test("external");
        bus_write(reg_control, 32'h3);
        repeat ((cfg_period + 1) * 2 * ext_half) @(negedge clock);
        set_expected(2 * ext_half - 1);
        measure_period();
        end_test();

        begin_test("fault");
        @(negedge clock);
        fault = 1'b1;
        repeat (2) @(negedge clock);
        check_value("outputs after fault", 0, int'(pwm_out));
        bus_read(reg_status, data);
        // Faulted state in bits 1:0 and fault_latched in bit 2
        check_value("status", int'(st_faulted) + 4, data);
        fault = 1'b0;
        nonzero_clocks = 0;
        repeat (window_clocks) begin
            @(negedge clock);
            if (pwm_out != '0) nonzero_clocks++;
        end
        check_value("clocks active before clear", 0, nonzero_clocks);
        // Clear the fault and enable again on the internal timebase
        bus_write(reg_control, 32'h5);
        set_expected(cfg_prescale);
        measure_period();
        end_test();

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
